// ==== source/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // one enable per byte lane of a data word
    typedef logic [3:0] byte_en_t;

    // major opcodes in instruction bits 6 to 0
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // same codes as the branch funct3
    typedef enum logic [2:0] {
        cmp_eq  = 3'b000,
        cmp_ne  = 3'b001,
        cmp_lt  = 3'b100,
        cmp_ge  = 3'b101,
        cmp_ltu = 3'b110,
        cmp_geu = 3'b111
    } cmp_op_t;

    // load and store widths as funct3 encodes them
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_size_t;

    typedef enum logic [2:0] {
        wb_alu,
        wb_cmp,
        wb_imm,
        wb_load,
        wb_link
    } wb_sel_t;

    typedef enum logic {
        a_rs1,
        a_pc
    } a_sel_t;

    typedef enum logic {
        b_imm,
        b_rs2
    } b_sel_t;

endpackage

// ==== source/register_file.sv ====
module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t src_a,
    input  reg_addr_t src_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    input  logic      write,
    input  reg_addr_t dest,
    input  word_t     wr_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && dest != '0) begin
            regs[dest] <= wr_data;
        end
    end

    // same-cycle write is seen by the reader
    assign rd_data_a = (src_a == '0) ? '0 :
                       (write && dest == src_a) ? wr_data : regs[src_a];
    assign rd_data_b = (src_b == '0) ? '0 :
                       (write && dest == src_b) ? wr_data : regs[src_b];

endmodule

// ==== source/decode_stage.sv ====
module decode_stage import rv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic      clk,
    input  logic      rst,
    output word_t     imem_address,
    input  word_t     imem_rdata,
    input  logic      redirect,
    input  word_t     redirect_pc,
    input  logic      rf_write,
    input  reg_addr_t rf_addr,
    input  word_t     rf_data,
    output logic      ex_valid,
    output word_t     ex_pc,
    output opcode_t   ex_opcode,
    output reg_addr_t ex_rs1,
    output reg_addr_t ex_rs2,
    output reg_addr_t ex_rd,
    output word_t     ex_rs1_data,
    output word_t     ex_rs2_data,
    output word_t     ex_imm,
    output alu_op_t   ex_alu_op,
    output cmp_op_t   ex_cmp_op,
    output mem_size_t ex_mem_size,
    output a_sel_t    ex_a_sel,
    output b_sel_t    ex_b_sel,
    output wb_sel_t   ex_wb_sel,
    output logic      ex_reg_write
);

    word_t      pc;
    logic       if_valid;
    word_t      if_instr;
    word_t      if_pc;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;

    logic       legal;
    alu_op_t    alu_op;
    cmp_op_t    cmp_op;
    mem_size_t  mem_size;
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    wb_sel_t    wb_sel;
    logic       reg_write;

    assign imem_address = pc;

    // not-taken fetch, execute overrides on a redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // word arriving during a redirect is on the wrong path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if_instr <= imem_rdata;
        if_pc    <= pc;
    end

    assign opcode = opcode_t'(if_instr[6:0]);
    assign funct3 = if_instr[14:12];
    // sub and sra select
    assign alt    = if_instr[30];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign rd     = if_instr[11:7];

    // one immediate per format
    always_comb begin
        case (opcode)
            op_lui, op_auipc: imm = {if_instr[31:12], 12'h000};
            op_jal: imm = {{12{if_instr[31]}}, if_instr[19:12], if_instr[20],
                           if_instr[30:21], 1'b0};
            op_br: imm = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25],
                          if_instr[11:8], 1'b0};
            op_store: imm = {{21{if_instr[31]}}, if_instr[30:25], if_instr[11:7]};
            default: imm = {{21{if_instr[31]}}, if_instr[30:20]};
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000: mem_size = mem_b;
            3'b001: mem_size = mem_h;
            3'b100: mem_size = mem_bu;
            3'b101: mem_size = mem_hu;
            default: mem_size = mem_w;
        endcase
    end

    always_comb begin
        legal     = 1'b1;
        alu_op    = alu_add;
        cmp_op    = cmp_lt;
        a_sel     = a_rs1;
        b_sel     = b_imm;
        wb_sel    = wb_alu;
        reg_write = 1'b1;
        case (opcode)
            op_lui: wb_sel = wb_imm;
            op_auipc: a_sel = a_pc;
            op_jal: begin
                a_sel  = a_pc;
                wb_sel = wb_link;
            end
            op_jalr: wb_sel = wb_link;
            op_br: begin
                // alu forms the target, comparator takes rs2
                a_sel     = a_pc;
                reg_write = 1'b0;
                case (funct3)
                    3'b000: cmp_op = cmp_eq;
                    3'b001: cmp_op = cmp_ne;
                    3'b100: cmp_op = cmp_lt;
                    3'b101: cmp_op = cmp_ge;
                    3'b110: cmp_op = cmp_ltu;
                    default: cmp_op = cmp_geu;
                endcase
            end
            op_load: wb_sel = wb_load;
            op_store: reg_write = 1'b0;
            op_imm, op_reg: begin
                if (opcode == op_reg) begin
                    b_sel = b_rs2;
                end
                case (funct3)
                    3'b000: alu_op = (opcode == op_reg && alt) ? alu_sub : alu_add;
                    3'b001: alu_op = alu_sll;
                    3'b010: begin
                        cmp_op = cmp_lt;
                        wb_sel = wb_cmp;
                    end
                    3'b011: begin
                        cmp_op = cmp_ltu;
                        wb_sel = wb_cmp;
                    end
                    3'b100: alu_op = alu_xor;
                    3'b101: alu_op = alt ? alu_sra : alu_srl;
                    3'b110: alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            default: begin
                legal     = 1'b0;
                reg_write = 1'b0;
            end
        endcase
    end

    register_file regs0 (
        .clk       (clk),
        .rst       (rst),
        .src_a     (rs1),
        .src_b     (rs2),
        .rd_data_a (rs1_data),
        .rd_data_b (rs2_data),
        .write     (rf_write),
        .dest      (rf_addr),
        .wr_data   (rf_data)
    );

    // the decoded instruction is dropped by a redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= if_valid && legal && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= if_pc;
        ex_opcode    <= opcode;
        ex_rs1       <= rs1;
        ex_rs2       <= rs2;
        ex_rd        <= rd;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_imm       <= imm;
        ex_alu_op    <= alu_op;
        ex_cmp_op    <= cmp_op;
        ex_mem_size  <= mem_size;
        ex_a_sel     <= a_sel;
        ex_b_sel     <= b_sel;
        ex_wb_sel    <= wb_sel;
        ex_reg_write <= reg_write;
    end

endmodule

// ==== source/execute_stage.sv ====
module execute_stage import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ex_valid,
    input  word_t      ex_pc,
    input  opcode_t    ex_opcode,
    input  reg_addr_t  ex_rs1,
    input  reg_addr_t  ex_rs2,
    input  reg_addr_t  ex_rd,
    input  word_t      ex_rs1_data,
    input  word_t      ex_rs2_data,
    input  word_t      ex_imm,
    input  alu_op_t    ex_alu_op,
    input  cmp_op_t    ex_cmp_op,
    input  mem_size_t  ex_mem_size,
    input  a_sel_t     ex_a_sel,
    input  b_sel_t     ex_b_sel,
    input  wb_sel_t    ex_wb_sel,
    input  logic       ex_reg_write,
    input  word_t      rf_data,
    output logic       redirect,
    output word_t      redirect_pc,
    output logic       dmem_read,
    output logic       dmem_write,
    output word_t      dmem_address,
    output word_t      dmem_wdata,
    output byte_en_t   dmem_byte_enable,
    input  word_t      dmem_rdata,
    output logic       wb_valid,
    output reg_addr_t  wb_rd,
    output logic       wb_reg_write,
    output wb_sel_t    wb_wb_sel,
    output mem_size_t  wb_mem_size,
    output word_t      wb_alu,
    output logic       wb_cmp,
    output word_t      wb_imm,
    output word_t      wb_link,
    output word_t      wb_load_data,
    output logic [1:0] wb_byte_offset
);

    word_t      rs1_fwd;
    word_t      rs2_fwd;
    word_t      alu_a;
    word_t      alu_b;
    word_t      cmp_b;
    word_t      alu_out;
    logic       cmp_true;
    logic [1:0] offset;

    // result stage holds the only producer newer than the register file
    function automatic word_t forward(reg_addr_t src, word_t data);
        if (wb_valid && wb_reg_write && src != '0 && wb_rd == src) begin
            return rf_data;
        end
        return data;
    endfunction

    always_comb begin
        rs1_fwd = forward(ex_rs1, ex_rs1_data);
        rs2_fwd = forward(ex_rs2, ex_rs2_data);
    end

    assign alu_a = (ex_a_sel == a_pc) ? ex_pc : rs1_fwd;
    assign alu_b = (ex_b_sel == b_imm) ? ex_imm : rs2_fwd;
    // branches use the alu for the target
    assign cmp_b = (ex_opcode == op_br) ? rs2_fwd : alu_b;

    always_comb begin
        case (ex_alu_op)
            alu_add: alu_out = alu_a + alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_sra: alu_out = word_t'($signed(alu_a) >>> alu_b[4:0]);
            alu_sub: alu_out = alu_a - alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            alu_or: alu_out = alu_a | alu_b;
            default: alu_out = alu_a & alu_b;
        endcase
    end

    always_comb begin
        case (ex_cmp_op)
            cmp_eq: cmp_true = rs1_fwd == cmp_b;
            cmp_ne: cmp_true = rs1_fwd != cmp_b;
            cmp_lt: cmp_true = $signed(rs1_fwd) < $signed(cmp_b);
            cmp_ge: cmp_true = $signed(rs1_fwd) >= $signed(cmp_b);
            cmp_ltu: cmp_true = rs1_fwd < cmp_b;
            default: cmp_true = rs1_fwd >= cmp_b;
        endcase
    end

    // jumps always redirect, branches only when taken
    assign redirect = ex_valid && (ex_opcode == op_jal || ex_opcode == op_jalr ||
                                   (ex_opcode == op_br && cmp_true));
    assign redirect_pc = (ex_opcode == op_jalr) ? {alu_out[31:1], 1'b0} : alu_out;

    assign offset       = alu_out[1:0];
    assign dmem_read    = ex_valid && ex_opcode == op_load;
    assign dmem_write   = ex_valid && ex_opcode == op_store;
    assign dmem_address = {alu_out[31:2], 2'b00};
    // store data moved to its byte lane
    assign dmem_wdata   = rs2_fwd << {offset, 3'b000};

    always_comb begin
        if (dmem_write) begin
            case (ex_mem_size)
                mem_b: dmem_byte_enable = 4'b0001 << offset;
                mem_h: dmem_byte_enable = 4'b0011 << offset;
                default: dmem_byte_enable = 4'b1111;
            endcase
        end else begin
            dmem_byte_enable = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd          <= ex_rd;
        wb_reg_write   <= ex_reg_write;
        wb_wb_sel      <= ex_wb_sel;
        wb_mem_size    <= ex_mem_size;
        wb_alu         <= alu_out;
        wb_cmp         <= cmp_true;
        wb_imm         <= ex_imm;
        wb_link        <= ex_pc + 32'd4;
        wb_load_data   <= dmem_rdata;
        wb_byte_offset <= offset;
    end

endmodule

// ==== source/result_stage.sv ====
module result_stage import rv_pkg::*; (
    input  logic       wb_valid,
    input  reg_addr_t  wb_rd,
    input  logic       wb_reg_write,
    input  wb_sel_t    wb_wb_sel,
    input  mem_size_t  wb_mem_size,
    input  word_t      wb_alu,
    input  logic       wb_cmp,
    input  word_t      wb_imm,
    input  word_t      wb_link,
    input  word_t      wb_load_data,
    input  logic [1:0] wb_byte_offset,
    output logic       rf_write,
    output reg_addr_t  rf_addr,
    output word_t      rf_data
);

    word_t lane;
    word_t load_value;

    // addressed byte or halfword moved down to bit 0
    assign lane = wb_load_data >> {wb_byte_offset, 3'b000};

    always_comb begin
        case (wb_mem_size)
            mem_b: load_value = {{24{lane[7]}}, lane[7:0]};
            mem_bu: load_value = {24'h000000, lane[7:0]};
            mem_h: load_value = {{16{lane[15]}}, lane[15:0]};
            mem_hu: load_value = {16'h0000, lane[15:0]};
            default: load_value = wb_load_data;
        endcase
    end

    // literals are scoped since the ports share their names
    always_comb begin
        case (wb_wb_sel)
            rv_pkg::wb_cmp: rf_data = {31'b0, wb_cmp};
            rv_pkg::wb_imm: rf_data = wb_imm;
            rv_pkg::wb_load: rf_data = load_value;
            rv_pkg::wb_link: rf_data = wb_link;
            default: rf_data = wb_alu;
        endcase
    end

    assign rf_write = wb_valid && wb_reg_write && wb_rd != '0;
    assign rf_addr  = wb_rd;

endmodule

// ==== source/rv_core.sv ====
module rv_core import rv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic     clk,
    input  logic     rst,
    output word_t    imem_address,
    input  word_t    imem_rdata,
    output logic     dmem_read,
    output logic     dmem_write,
    output word_t    dmem_address,
    output word_t    dmem_wdata,
    output byte_en_t dmem_byte_enable,
    input  word_t    dmem_rdata
);

    // decode to execute
    logic      ex_valid;
    word_t     ex_pc;
    opcode_t   ex_opcode;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    word_t     ex_imm;
    alu_op_t   ex_alu_op;
    cmp_op_t   ex_cmp_op;
    mem_size_t ex_mem_size;
    a_sel_t    ex_a_sel;
    b_sel_t    ex_b_sel;
    wb_sel_t   ex_wb_sel;
    logic      ex_reg_write;

    // execute back to fetch
    logic  redirect;
    word_t redirect_pc;

    // execute to result
    logic      wb_valid;
    reg_addr_t wb_rd;
    logic      wb_reg_write;
    wb_sel_t   wb_wb_sel;
    mem_size_t wb_mem_size;
    word_t     wb_alu;
    logic      wb_cmp;
    word_t     wb_imm;
    word_t     wb_link;
    word_t     wb_load_data;
    logic [1:0] wb_byte_offset;

    // register write, also the forwarding source
    logic      rf_write;
    reg_addr_t rf_addr;
    word_t     rf_data;

    decode_stage #(.reset_pc(reset_pc)) decode0 (.*);

    execute_stage execute0 (.*);

    result_stage result0 (.*);

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        // release just after the edge like every other input
        #1 rst = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

// ==== testbench/rv_core_asserts.sv ====
module rv_core_asserts import rv_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     redirect,
    input logic     dmem_read,
    input logic     dmem_write,
    input byte_en_t dmem_byte_enable
);

    timeunit 1ns;
    timeprecision 100ps;

    // both younger instructions are squashed by a redirect
    squash_after_redirect: assert property (@(posedge clk) disable iff (rst)
        ($past(redirect) || $past(redirect, 2)) |-> !dmem_read && !dmem_write)
        else $error("memory strobe raised by a squashed instruction");

    quiet_in_reset: assert property (@(posedge clk) rst |-> !dmem_read && !dmem_write)
        else $error("memory strobe raised during reset");

    // one byte, an aligned halfword or the full word
    store_lanes_legal: assert property (@(posedge clk) dmem_write |->
        dmem_byte_enable inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0011, 4'b1100, 4'b1111})
        else $error("store issued with an illegal byte enable");

endmodule

bind execute_stage rv_core_asserts chk0 (
    .clk              (clk),
    .rst              (rst),
    .redirect         (redirect),
    .dmem_read        (dmem_read),
    .dmem_write       (dmem_write),
    .dmem_byte_enable (dmem_byte_enable)
);

// ==== testbench/tb_rv_core.sv ====
module tb_rv_core import rv_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t reset_pc = 32'h0000_0100;
    localparam word_t nop = 32'h0000_0013;
    localparam int prog_words = 128;

    logic     clk;
    logic     rst;
    word_t    imem_address;
    word_t    imem_rdata;
    logic     dmem_read;
    logic     dmem_write;
    word_t    dmem_address;
    word_t    dmem_wdata;
    byte_en_t dmem_byte_enable;
    word_t    dmem_rdata;

    // stimulus table, one entry per instruction
    word_t    table_instr [$];
    logic     table_store [$];
    word_t    table_addr [$];
    word_t    table_data [$];
    byte_en_t table_be [$];

    // stores still to come, oldest first
    word_t    exp_addr [$];
    word_t    exp_data [$];
    byte_en_t exp_be [$];

    word_t prog_mem [prog_words];
    logic [7:0] data_mem [256][4];
    int cycles = 0;
    int limit;

    tb_clock_gen clock0 (.clk(clk), .rst(rst));

    rv_core #(.reset_pc(reset_pc)) dut0 (.*);

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic add_row(word_t instr, logic st, word_t a, word_t d, byte_en_t be);
        table_instr.push_back(instr);
        table_store.push_back(st);
        table_addr.push_back(a);
        table_data.push_back(d);
        table_be.push_back(be);
    endtask

    task automatic plain(word_t instr);
        add_row(instr, 1'b0, '0, '0, '0);
    endtask

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(string name, word_t got, word_t expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic check_enable(string name, byte_en_t got, byte_en_t expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    function automatic word_t fetch(word_t address);
        word_t off;
        off = address - reset_pc;
        if (off[1:0] == 2'b00 && off[31:2] < prog_words) begin
            return prog_mem[off[8:2]];
        end
        return nop;
    endfunction

    // memories answer 1 ns after the edge, stores land on the edge
    always @(posedge clk) begin : mem_model
        cycles++;
        if (rst && (dmem_read || dmem_write)) begin
            stop_with_failure("a memory strobe was raised during reset");
        end
        if (!rst && dmem_write) begin
            if (exp_addr.size() == 0) begin
                stop_with_failure("a store appeared that the program should not make");
            end
            check_word("dmem_address", dmem_address, exp_addr.pop_front());
            check_word("dmem_wdata", dmem_wdata, exp_data.pop_front());
            check_enable("dmem_byte_enable", dmem_byte_enable, exp_be.pop_front());
            for (int l = 0; l < 4; l++) begin
                if (dmem_byte_enable[l]) begin
                    data_mem[dmem_address[9:2]][l] = dmem_wdata[8*l +: 8];
                end
            end
        end
        #1;
        imem_rdata = fetch(imem_address);
        // read data only while a load is in execute
        dmem_rdata = '0;
        if (dmem_read) begin
            for (int l = 0; l < 4; l++) begin
                dmem_rdata[8*l +: 8] = data_mem[dmem_address[9:2]][l];
            end
        end
    end

    initial begin
        imem_rdata = nop;
        dmem_rdata = '0;
        // fill byte depends on the full 10-bit byte address
        for (int w = 0; w < 256; w++) begin
            for (int l = 0; l < 4; l++) begin
                data_mem[w][l] = 8'(w * 4 + l) ^ 8'((w * 4 + l) >> 8) ^ 8'h5a;
            end
        end
        plain(enc_i(12'h200, 0, 3'd0, 10, op_imm));
        plain(enc_i(12'hffb, 0, 3'd0, 1, op_imm));
        plain(enc_i(12'h007, 0, 3'd0, 2, op_imm));
        plain(enc_r(7'h00, 2, 1, 3'd0, 3));
        add_row(enc_s(12'h000, 3, 10, 3'd2), 1, 32'h200, 32'h2, 4'hf);
        plain(enc_r(7'h20, 1, 2, 3'd0, 4));
        add_row(enc_s(12'h004, 4, 10, 3'd2), 1, 32'h204, 32'hc, 4'hf);
        plain(enc_r(7'h00, 2, 1, 3'd2, 5));
        plain(enc_r(7'h00, 2, 1, 3'd3, 6));
        add_row(enc_s(12'h008, 5, 10, 3'd2), 1, 32'h208, 32'h1, 4'hf);
        add_row(enc_s(12'h00c, 6, 10, 3'd2), 1, 32'h20c, 32'h0, 4'hf);
        plain(enc_i(12'h0f0, 1, 3'd4, 7, op_imm));
        plain(enc_i(12'h401, 1, 3'd5, 8, op_imm));
        add_row(enc_s(12'h010, 7, 10, 3'd2), 1, 32'h210, 32'hffff_ff0b, 4'hf);
        add_row(enc_s(12'h014, 8, 10, 3'd2), 1, 32'h214, 32'hffff_fffd, 4'hf);
        plain(enc_i(12'h01c, 1, 3'd5, 9, op_imm));
        add_row(enc_s(12'h018, 9, 10, 3'd2), 1, 32'h218, 32'hf, 4'hf);
        plain(enc_i(12'h004, 2, 3'd1, 11, op_imm));
        plain(enc_r(7'h00, 2, 11, 3'd6, 12));
        plain(enc_r(7'h00, 1, 12, 3'd7, 13));
        add_row(enc_s(12'h01c, 13, 10, 3'd2), 1, 32'h21c, 32'h73, 4'hf);
        plain(enc_u(20'h12345, 14, op_lui));
        add_row(enc_s(12'h020, 14, 10, 3'd2), 1, 32'h220, 32'h1234_5000, 4'hf);
        plain(enc_u(20'h00001, 15, op_auipc));
        add_row(enc_s(12'h024, 15, 10, 3'd2), 1, 32'h224, 32'h115c, 4'hf);
        // sub-word stores at every lane
        plain(enc_i(12'h7a5, 0, 3'd0, 16, op_imm));
        add_row(enc_s(12'h030, 16, 10, 3'd0), 1, 32'h230, 32'h0000_07a5, 4'b0001);
        add_row(enc_s(12'h031, 16, 10, 3'd0), 1, 32'h230, 32'h0007_a500, 4'b0010);
        add_row(enc_s(12'h032, 16, 10, 3'd0), 1, 32'h230, 32'h07a5_0000, 4'b0100);
        add_row(enc_s(12'h033, 16, 10, 3'd0), 1, 32'h230, 32'ha500_0000, 4'b1000);
        add_row(enc_s(12'h034, 1, 10, 3'd1), 1, 32'h234, 32'hffff_fffb, 4'b0011);
        add_row(enc_s(12'h036, 16, 10, 3'd1), 1, 32'h234, 32'h07a5_0000, 4'b1100);
        // loads with their consumer right behind
        plain(enc_i(12'h031, 10, 3'd0, 17, op_load));
        add_row(enc_s(12'h040, 17, 10, 3'd2), 1, 32'h240, 32'hffff_ffa5, 4'hf);
        plain(enc_i(12'h033, 10, 3'd4, 18, op_load));
        add_row(enc_s(12'h044, 18, 10, 3'd2), 1, 32'h244, 32'ha5, 4'hf);
        plain(enc_i(12'h034, 10, 3'd1, 19, op_load));
        add_row(enc_s(12'h048, 19, 10, 3'd2), 1, 32'h248, 32'hffff_fffb, 4'hf);
        plain(enc_i(12'h036, 10, 3'd5, 20, op_load));
        add_row(enc_s(12'h04c, 20, 10, 3'd2), 1, 32'h24c, 32'h7a5, 4'hf);
        plain(enc_i(12'h034, 10, 3'd5, 21, op_load));
        add_row(enc_s(12'h050, 21, 10, 3'd2), 1, 32'h250, 32'hfffb, 4'hf);
        plain(enc_i(12'h030, 10, 3'd2, 22, op_load));
        plain(enc_i(12'h001, 22, 3'd0, 23, op_imm));
        add_row(enc_s(12'h054, 23, 10, 3'd2), 1, 32'h254, 32'ha5a5_a5a6, 4'hf);
        // branches, skipped stores must never show up
        plain(enc_b(13'd12, 2, 2, 3'd0));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_b(13'd12, 2, 2, 3'd1));
        add_row(enc_s(12'h060, 2, 10, 3'd2), 1, 32'h260, 32'h7, 4'hf);
        plain(enc_b(13'd12, 2, 1, 3'd4));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_b(13'd12, 2, 1, 3'd6));
        add_row(enc_s(12'h068, 1, 10, 3'd2), 1, 32'h268, 32'hffff_fffb, 4'hf);
        plain(enc_b(13'd12, 1, 2, 3'd5));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_b(13'd12, 2, 1, 3'd7));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_j(21'd12, 24));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        add_row(enc_s(12'h06c, 24, 10, 3'd2), 1, 32'h26c, 32'h1f8, 4'hf);
        plain(enc_u(20'h00000, 25, op_auipc));
        // target 0x219 with bit 0 cleared
        plain(enc_i(12'h015, 25, 3'd0, 26, op_jalr));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        plain(enc_s(12'h07c, 2, 10, 3'd2));
        add_row(enc_s(12'h070, 26, 10, 3'd2), 1, 32'h270, 32'h20c, 4'hf);
        plain(nop);

        for (int i = 0; i < prog_words; i++) begin
            prog_mem[i] = nop;
        end
        for (int i = 0; i < table_instr.size(); i++) begin
            prog_mem[i] = table_instr[i];
            if (table_store[i]) begin
                exp_addr.push_back(table_addr[i]);
                exp_data.push_back(table_data[i]);
                exp_be.push_back(table_be[i]);
            end
        end
        limit = 4 * table_instr.size() + 40;

        @(negedge rst);
        check_word("imem_address", imem_address, reset_pc);
        while (exp_addr.size() != 0 && cycles < limit) begin
            @(posedge clk);
        end
        // a few more cycles to catch any stray store
        repeat (4) @(posedge clk);
        if (exp_addr.size() == 0 && cycles < limit) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("timeout after %0d cycles, %0d stores never seen", cycles,
                     exp_addr.size());
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

// ==== rv_core.f ====
source/rv_pkg.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/rv_core.sv
testbench/tb_clock_gen.sv
testbench/rv_core_asserts.sv
testbench/tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
